// File: ahb_cache.f
src/cache_pkg.sv
src/ahb_req_decode.sv
src/cache_store.sv
src/line_refill.sv
src/cache_response.sv
src/ahb_cache_top.sv
tb/ahb_cache_tb.sv

// File: Makefile
# Verilator build and run of the cache testbench.

.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal --top-module ahb_cache_tb \
		-f ahb_cache.f -o ahb_cache_sim
	./obj_dir/ahb_cache_sim | tee /dev/stderr | grep -qx "test passed"

clean:
	rm -rf obj_dir

// File: tb/ahb_cache_tb.sv
`timescale 1ns/1ps

module ahb_cache_tb;

    import cache_pkg::*;

    localparam int cache_bytes = 8192;
    localparam int num_lines   = cache_bytes / (line_words * 4);
    localparam int index_bits  = $clog2(num_lines);
    localparam int max_cycles  = 4000;  // about forty transfers of 24 cycles, plus margin.

    logic    upstream_intf = 1'b0;
    logic    reset = 1'b1;
    word_t   up_haddr = '0;
    htrans_t up_htrans = trans_idle;
    logic    up_hwrite = 1'b0;
    word_t   up_hwdata = '0;
    word_t   up_hrdata;
    logic    up_hready;
    word_t   dn_haddr;
    htrans_t dn_htrans;
    hburst_t dn_hburst;
    logic    dn_hwrite;
    word_t   dn_hwdata;
    word_t   dn_hrdata = '0;
    logic    dn_hready = 1'b1;

    integer  seed = 32'hbc0a658b;
    int      cycles = 0;
    int      errors = 0;
    int      tests_ok = 0;
    int      tests_bad = 0;
    int      max_wait = 0;
    int      idx;
    logic    rst_seen = 1'b0;
    word_t   wdata_exp = '0;

    // ====================
    // reference models
    // ====================

    word_t       mem_written [word_t];
    logic        line_valid [num_lines];
    logic [27:0] line_addr [num_lines];

    // downstream slave state.
    logic  dn_pend = 1'b0;
    logic  dn_pend_write = 1'b0;
    word_t dn_pend_addr = '0;
    int    wait_left = 0;
    word_t last_dn_addr = '0;
    word_t next_wrap_addr;
    int    dn_data_cnt = 0;
    int    dn_seq_cnt = 0;

    // upstream data phase.
    logic  up_dphase = 1'b0;
    logic  up_dfirst = 1'b0;
    logic  up_dwrite = 1'b0;
    logic  exp_hit = 1'b0;
    word_t up_daddr = '0;
    word_t exp_rdata = '0;

    ahb_cache_top #(.cache_bytes(cache_bytes)) ahb_cache_top_inst (
        .upstream_intf (upstream_intf),
        .reset         (reset),
        .up_haddr      (up_haddr),
        .up_htrans     (up_htrans),
        .up_hwrite     (up_hwrite),
        .up_hwdata     (up_hwdata),
        .up_hrdata     (up_hrdata),
        .up_hready     (up_hready),
        .dn_haddr      (dn_haddr),
        .dn_htrans     (dn_htrans),
        .dn_hburst     (dn_hburst),
        .dn_hwrite     (dn_hwrite),
        .dn_hwdata     (dn_hwdata),
        .dn_hrdata     (dn_hrdata),
        .dn_hready     (dn_hready)
    );

    always #20 upstream_intf = ~upstream_intf;

    // written words, else a pattern over the full address.
    function automatic word_t mem_word(input word_t addr);
        if (mem_written.exists(addr)) begin
            return mem_written[addr];
        end
        return {addr[15:0], addr[31:16]} ^ 32'h3c5a_96e1;
    endfunction

    assign next_wrap_addr = {last_dn_addr[31:4], last_dn_addr[3:2] + 2'd1, 2'b00};

    always @(posedge upstream_intf) begin
        rst_seen <= 1'b1;
        cycles   <= cycles + 1;
        up_dfirst <= 1'b0;
        if (reset) begin
            dn_pend   <= 1'b0;
            wait_left <= 0;
            up_dphase <= 1'b0;
            foreach (line_valid[i]) line_valid[i] = 1'b0;
        end else begin
            if (dn_hready) begin
                if (dn_pend && dn_pend_write) begin
                    mem_written[dn_pend_addr] = dn_hwdata;
                end
                dn_pend       <= dn_htrans == trans_nonseq || dn_htrans == trans_seq;
                dn_pend_addr  <= dn_haddr;
                dn_pend_write <= dn_hwrite;
                wait_left     <= $unsigned($random(seed)) % (max_wait + 1);
                if (dn_htrans != trans_idle) begin
                    last_dn_addr <= dn_haddr;
                end
            end else if (wait_left != 0) begin
                wait_left <= wait_left - 1;  // one wait state used.
            end
            if (up_hready) begin
                up_dphase <= up_htrans == trans_nonseq || up_htrans == trans_seq;
            end
            if (up_hready && (up_htrans == trans_nonseq || up_htrans == trans_seq)) begin
                idx = int'(up_haddr[4 +: index_bits]);
                up_dfirst   <= 1'b1;
                up_daddr    <= up_haddr;
                up_dwrite   <= up_hwrite;
                exp_hit     <= !up_hwrite && line_valid[idx] && line_addr[idx] == up_haddr[31:4];
                exp_rdata   <= mem_word(up_haddr);
                dn_data_cnt <= 0;
                dn_seq_cnt  <= 0;
                if (up_hwrite) begin
                    if (line_addr[idx] == up_haddr[31:4]) line_valid[idx] = 1'b0;
                end else begin
                    line_valid[idx] = 1'b1;
                    line_addr[idx]  = up_haddr[31:4];
                end
            end else begin
                dn_data_cnt <= dn_data_cnt + int'(dn_hready && dn_pend);
                dn_seq_cnt  <= dn_seq_cnt + int'(dn_hready && dn_htrans == trans_seq);
            end
        end
    end

    always @(negedge upstream_intf) begin
        dn_hready = !dn_pend || wait_left == 0;
        dn_hrdata = (dn_pend && !dn_pend_write && dn_hready) ? mem_word(dn_pend_addr) : '0;
    end

    always @(posedge upstream_intf) begin
        if (cycles >= max_cycles) begin
            $display("simulation timed out");
            $display("test failed");
            $finish;
        end
    end

    // ====================
    // checks
    // ====================

    assert property (@(posedge upstream_intf)
        (rst_seen && (reset || $past(reset))) |-> (up_hready && dn_htrans == trans_idle && !dn_hwrite))
        else begin
            $display("bus not quiet around reset: up_hready %h dn_htrans %h",
                     $sampled(up_hready), $sampled(dn_htrans));
            errors++;
        end

    assert property (@(posedge upstream_intf) disable iff (reset)
        (up_dphase && !up_dwrite && up_hready) |-> up_hrdata == exp_rdata)
        else begin
            $display("mismatch up_hrdata: expected %h, got %h", $sampled(exp_rdata),
                     $sampled(up_hrdata));
            errors++;
        end

    assert property (@(posedge upstream_intf) disable iff (reset)
        (up_dfirst && !up_dwrite && exp_hit) |-> (up_hready && dn_htrans == trans_idle))
        else begin
            $display("read hit at %h was not answered at once", $sampled(up_daddr));
            errors++;
        end

    assert property (@(posedge upstream_intf) disable iff (reset)
        (up_dfirst && !exp_hit) |-> !up_hready)
        else begin
            $display("miss or write at %h finished with no wait state", $sampled(up_daddr));
            errors++;
        end

    assert property (@(posedge upstream_intf) disable iff (reset)
        (up_dfirst && !up_dwrite && !exp_hit) |=> (dn_htrans == trans_nonseq &&
        dn_hburst == burst_wrap4 && !dn_hwrite && dn_haddr == up_daddr))
        else begin
            $display("read miss at %h did not start a wrap4 burst there", $sampled(up_daddr));
            errors++;
        end

    assert property (@(posedge upstream_intf) disable iff (reset)
        (up_dfirst && up_dwrite) |=> (dn_htrans == trans_nonseq &&
        dn_hburst == burst_single && dn_hwrite && dn_haddr == up_daddr))
        else begin
            $display("write at %h did not start a single downstream write", $sampled(up_daddr));
            errors++;
        end

    assert property (@(posedge upstream_intf) disable iff (reset)
        (dn_htrans == trans_seq) |-> (dn_hburst == burst_wrap4 && dn_haddr == next_wrap_addr))
        else begin
            $display("mismatch dn_haddr: expected %h, got %h", $sampled(next_wrap_addr),
                     $sampled(dn_haddr));
            errors++;
        end

    assert property (@(posedge upstream_intf) disable iff (reset)
        (dn_pend && dn_pend_write && dn_hready) |-> dn_hwdata == wdata_exp)
        else begin
            $display("mismatch dn_hwdata: expected %h, got %h", $sampled(wdata_exp),
                     $sampled(dn_hwdata));
            errors++;
        end

    // a line takes one nonseq and three seq beats, a write one beat.
    assert property (@(posedge upstream_intf) disable iff (reset)
        (up_dphase && up_hready && !exp_hit) |->
        (dn_data_cnt == (up_dwrite ? 1 : line_words) && dn_seq_cnt == (up_dwrite ? 0 : 3)))
        else begin
            $display("mismatch downstream beats: expected %h, got %h",
                     $sampled(up_dwrite) ? 1 : line_words, $sampled(dn_data_cnt));
            errors++;
        end

    assert property (@(posedge upstream_intf) disable iff (reset)
        up_hready |-> !dn_pend)
        else begin
            $display("up_hready high while a downstream beat was still pending");
            errors++;
        end

    // ====================
    // stimulus
    // ====================

    task automatic transfer(input word_t addr, input logic write, input word_t data);
        @(negedge upstream_intf);
        up_haddr  = addr;
        up_htrans = trans_nonseq;
        up_hwrite = write;
        @(negedge upstream_intf);
        up_htrans = trans_idle;
        up_hwdata = data;
        wdata_exp = data;
        while (!up_hready) @(negedge upstream_intf);
    endtask

    task automatic report_test(input string name, input int errors_before);
        @(negedge upstream_intf);
        if (errors == errors_before) begin
            tests_ok++;
            $display("%-16s ok", name);
        end else begin
            tests_bad++;
            $display("%-16s %0d errors", name, errors - errors_before);
        end
    endtask

    initial begin
        int    mark;
        word_t addr;
        mark = errors;
        repeat (5) @(posedge upstream_intf);
        @(negedge upstream_intf);
        reset = 1'b0;
        transfer(32'h0000_1040, 1'b0, '0);  // cold, so it must miss.
        report_test("reset_state", mark);

        mark = errors;
        transfer(32'h0000_2208, 1'b0, '0);
        transfer(32'h0000_330c, 1'b0, '0);
        report_test("cold_read_miss", mark);

        mark = errors;
        for (int i = 0; i < line_words; i++) begin
            transfer(32'h0000_2200 + 4 * i, 1'b0, '0);
            transfer(32'h0000_3300 + 4 * i, 1'b0, '0);
        end
        report_test("read_hit", mark);

        mark = errors;
        transfer(32'h0000_2208 + cache_bytes, 1'b0, '0);  // same index, new tag.
        transfer(32'h0000_2208, 1'b0, '0);
        transfer(32'h0000_2204, 1'b0, '0);
        report_test("conflict_evict", mark);

        mark = errors;
        transfer(32'h0000_2204, 1'b1, 32'ha5a5_1234);
        transfer(32'h0000_2204, 1'b0, '0);
        transfer(32'h0000_7000, 1'b1, 32'h0bad_f00d);
        transfer(32'h0000_7000, 1'b0, '0);
        report_test("write_through", mark);

        mark = errors;
        max_wait = 3;
        for (int i = 0; i < 24; i++) begin
            addr = $unsigned($random(seed)) & 32'h0000_3ffc;
            transfer(addr, i % 8 == 7, $random(seed));
        end
        report_test("back_pressure", mark);

        $display("%0d tests ok, %0d tests with errors", tests_ok, tests_bad);
        if (tests_bad == 0 && errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: src/ahb_cache_top.sv
`timescale 1ns/1ps

module ahb_cache_top #(
    parameter int cache_bytes = 8192
) (
    input  logic               upstream_intf,
    input  logic               reset,
    // upstream, the cache answers as a slave.
    input  cache_pkg::word_t   up_haddr,
    input  cache_pkg::htrans_t up_htrans,
    input  logic               up_hwrite,
    input  cache_pkg::word_t   up_hwdata,
    output cache_pkg::word_t   up_hrdata,
    output logic               up_hready,
    // downstream, the cache acts as master.
    output cache_pkg::word_t   dn_haddr,
    output cache_pkg::htrans_t dn_htrans,
    output cache_pkg::hburst_t dn_hburst,
    output logic               dn_hwrite,
    output cache_pkg::word_t   dn_hwdata,
    input  cache_pkg::word_t   dn_hrdata,
    input  logic               dn_hready
);

    import cache_pkg::*;

    localparam int num_lines  = cache_bytes / (line_words * 4);
    localparam int index_bits = $clog2(num_lines);
    localparam int tag_bits   = 32 - index_bits - offset_bits - 2;

    logic                   req_valid;
    logic                   req_write;
    logic [tag_bits-1:0]    req_tag;
    logic [index_bits-1:0]  req_index;
    logic [offset_bits-1:0] req_offset;
    word_t                  req_addr;
    word_t                  req_wdata;
    logic                   req_done;
    logic                   hit;
    word_t                  hit_word;
    logic                   fetch_start;
    logic                   write_start;
    logic                   invalidate;
    logic                   refill_done;
    word_t                  crit_word;
    logic                   fill_valid;
    line_t                  fill_line;

    ahb_req_decode #(.cache_bytes(cache_bytes)) ahb_req_decode_inst (
        .upstream_intf (upstream_intf),
        .reset         (reset),
        .up_haddr      (up_haddr),
        .up_htrans     (up_htrans),
        .up_hwrite     (up_hwrite),
        .up_hready     (up_hready),
        .up_hwdata     (up_hwdata),
        .req_done      (req_done),
        .req_valid     (req_valid),
        .req_write     (req_write),
        .req_tag       (req_tag),
        .req_index     (req_index),
        .req_offset    (req_offset),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata)
    );

    cache_store #(.cache_bytes(cache_bytes)) cache_store_inst (
        .upstream_intf (upstream_intf),
        .reset         (reset),
        .req_tag       (req_tag),
        .req_index     (req_index),
        .req_offset    (req_offset),
        .fill_valid    (fill_valid),
        .fill_line     (fill_line),
        .invalidate    (invalidate),
        .hit           (hit),
        .hit_word      (hit_word)
    );

    line_refill line_refill_inst (
        .upstream_intf (upstream_intf),
        .reset         (reset),
        .fetch_start   (fetch_start),
        .write_start   (write_start),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .dn_hready     (dn_hready),
        .dn_hrdata     (dn_hrdata),
        .dn_haddr      (dn_haddr),
        .dn_htrans     (dn_htrans),
        .dn_hburst     (dn_hburst),
        .dn_hwrite     (dn_hwrite),
        .dn_hwdata     (dn_hwdata),
        .fill_valid    (fill_valid),
        .fill_line     (fill_line),
        .crit_word     (crit_word),
        .refill_done   (refill_done)
    );

    cache_response cache_response_inst (
        .upstream_intf (upstream_intf),
        .reset         (reset),
        .req_valid     (req_valid),
        .req_write     (req_write),
        .hit           (hit),
        .hit_word      (hit_word),
        .refill_done   (refill_done),
        .crit_word     (crit_word),
        .fetch_start   (fetch_start),
        .write_start   (write_start),
        .invalidate    (invalidate),
        .req_done      (req_done),
        .up_hready     (up_hready),
        .up_hrdata     (up_hrdata)
    );

endmodule

// File: src/cache_response.sv
`timescale 1ns/1ps

module cache_response (
    input  logic             upstream_intf,
    input  logic             reset,
    input  logic             req_valid,
    input  logic             req_write,
    input  logic             hit,
    input  cache_pkg::word_t hit_word,
    input  logic             refill_done,
    input  cache_pkg::word_t crit_word,
    output logic             fetch_start,
    output logic             write_start,
    output logic             invalidate,
    output logic             req_done,
    output logic             up_hready,
    output cache_pkg::word_t up_hrdata
);

    import cache_pkg::*;

    logic  waiting;   // downstream work outstanding.
    logic  done_q;    // response cycle after refill_done.
    logic  fresh;
    logic  read_hit;
    word_t resp_word;

    assign fresh       = req_valid && !waiting && !done_q;
    assign read_hit    = fresh && !req_write && hit;
    assign fetch_start = fresh && !req_write && !hit;
    assign write_start = fresh && req_write;
    assign invalidate  = write_start;

    assign req_done  = read_hit || done_q;
    assign up_hready = !req_valid || req_done;
    assign up_hrdata = done_q ? resp_word : hit_word;  // hit path has no wait state.

    always_ff @(posedge upstream_intf) begin
        if (reset) begin
            waiting <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            done_q <= waiting && refill_done;
            if (fetch_start || write_start) begin
                waiting <= 1'b1;
            end else if (refill_done) begin
                waiting <= 1'b0;
            end
        end
    end

    always_ff @(posedge upstream_intf) begin
        if (refill_done) begin
            resp_word <= crit_word;
        end
    end

    // the refill engine only finishes work started here.
    assert property (@(posedge upstream_intf) disable iff (reset)
        refill_done |-> waiting)
        else $error("refill_done without an outstanding request.");

endmodule

// File: src/line_refill.sv
`timescale 1ns/1ps

module line_refill (
    input  logic               upstream_intf,
    input  logic               reset,
    input  logic               fetch_start,
    input  logic               write_start,
    input  cache_pkg::word_t   req_addr,
    input  cache_pkg::word_t   req_wdata,
    input  logic               dn_hready,
    input  cache_pkg::word_t   dn_hrdata,
    output cache_pkg::word_t   dn_haddr,
    output cache_pkg::htrans_t dn_htrans,
    output cache_pkg::hburst_t dn_hburst,
    output logic               dn_hwrite,
    output cache_pkg::word_t   dn_hwdata,
    output logic               fill_valid,
    output cache_pkg::line_t   fill_line,
    output cache_pkg::word_t   crit_word,
    output logic               refill_done
);

    import cache_pkg::*;

    typedef enum logic [1:0] {st_idle, st_addr, st_data} state_t;

    state_t                   state;
    logic                     is_write;
    logic [offset_bits:0]     addr_cnt;  // address beats accepted.
    logic [offset_bits-1:0]   data_cnt;  // data beats taken.
    logic [29-offset_bits:0]  line_base;
    logic [offset_bits-1:0]   crit_off;
    logic [offset_bits-1:0]   addr_off;
    logic [offset_bits-1:0]   data_off;
    logic                     last_beat;
    line_t                    line_buf;

    // wrap4 offsets roll over inside the line.
    assign addr_off  = crit_off + addr_cnt[offset_bits-1:0];
    assign data_off  = crit_off + data_cnt;
    assign last_beat = is_write || (data_cnt == line_words - 1);

    always_ff @(posedge upstream_intf) begin
        if (reset) begin
            state    <= st_idle;
            is_write <= 1'b0;
            addr_cnt <= '0;
            data_cnt <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (fetch_start || write_start) begin
                        state    <= st_addr;
                        is_write <= write_start;
                        addr_cnt <= '0;
                        data_cnt <= '0;
                    end
                end
                st_addr: begin
                    if (dn_hready) begin
                        state    <= st_data;
                        addr_cnt <= addr_cnt + 1'b1;
                    end
                end
                st_data: begin
                    // next address rides along with the current data beat.
                    if (dn_hready) begin
                        data_cnt <= data_cnt + 1'b1;
                        if (addr_cnt != line_words) begin
                            addr_cnt <= addr_cnt + 1'b1;
                        end
                        if (last_beat) begin
                            state <= st_idle;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge upstream_intf) begin
        if (state == st_idle && (fetch_start || write_start)) begin
            line_base <= req_addr[31:offset_bits+2];
            crit_off  <= req_addr[2 +: offset_bits];
        end
        if (state == st_data && dn_hready && !is_write) begin
            line_buf[data_off*32 +: 32] <= dn_hrdata;
        end
    end

    // ====================
    // downstream bus
    // ====================

    always_comb begin
        dn_htrans = trans_idle;
        dn_hburst = burst_single;
        if (state == st_addr) begin
            dn_htrans = trans_nonseq;
        end else if (state == st_data && !is_write && addr_cnt != line_words) begin
            dn_htrans = trans_seq;
        end
        if (state != st_idle && !is_write) begin
            dn_hburst = burst_wrap4;
        end
    end

    assign dn_haddr  = {line_base, addr_off, 2'b00};
    assign dn_hwrite = (state == st_addr) && is_write;
    assign dn_hwdata = (state == st_data && is_write) ? req_wdata : '0;

    assign refill_done = (state == st_data) && dn_hready && last_beat;
    assign fill_valid  = refill_done && !is_write;
    assign crit_word   = line_buf[crit_off*32 +: 32];  // first beat of the burst.

    always_comb begin
        fill_line = line_buf;
        fill_line[data_off*32 +: 32] = dn_hrdata;  // last beat goes straight in.
    end

    // starts only arrive while the engine is idle.
    assert property (@(posedge upstream_intf) disable iff (reset)
        (state != st_idle) |-> !(fetch_start || write_start))
        else $error("refill start while the downstream engine is busy.");

endmodule

// File: src/cache_store.sv
`timescale 1ns/1ps

module cache_store #(
    parameter int  cache_bytes = 8192,
    localparam int num_lines   = cache_bytes / (cache_pkg::line_words * 4),
    localparam int index_bits  = $clog2(num_lines),
    localparam int tag_bits    = 32 - index_bits - cache_pkg::offset_bits - 2
) (
    input  logic                              upstream_intf,
    input  logic                              reset,
    input  logic [tag_bits-1:0]               req_tag,
    input  logic [index_bits-1:0]             req_index,
    input  logic [cache_pkg::offset_bits-1:0] req_offset,
    input  logic                              fill_valid,
    input  cache_pkg::line_t                  fill_line,
    input  logic                              invalidate,
    output logic                              hit,
    output cache_pkg::word_t                  hit_word
);

    import cache_pkg::*;

    // ====================
    // arrays
    // ====================

    logic [num_lines-1:0] valid;
    logic [tag_bits-1:0]  tag_mem [num_lines];
    line_t                line_mem [num_lines];

    line_t                sel_line;
    logic                 tag_match;

    // ====================
    // lookup
    // ====================

    assign sel_line  = line_mem[req_index];
    assign tag_match = tag_mem[req_index] == req_tag;
    assign hit       = valid[req_index] && tag_match;
    assign hit_word  = sel_line[req_offset*32 +: 32];  // addressed word.

    // ====================
    // update
    // ====================

    // all lines go invalid in a single reset cycle.
    always_ff @(posedge upstream_intf) begin
        if (reset) begin
            valid <= '0;
        end else if (fill_valid) begin
            valid[req_index] <= 1'b1;
        end else if (invalidate && hit) begin
            valid[req_index] <= 1'b0;  // only when the written line is here.
        end
    end

    always_ff @(posedge upstream_intf) begin
        if (fill_valid) begin
            tag_mem[req_index]  <= req_tag;
            line_mem[req_index] <= fill_line;
        end
    end

    // fill comes from a read, invalidate from a write.
    assert property (@(posedge upstream_intf) disable iff (reset)
        !(fill_valid && invalidate))
        else $error("line fill and invalidate in the same cycle.");

endmodule

// File: src/ahb_req_decode.sv
`timescale 1ns/1ps

module ahb_req_decode #(
    parameter int  cache_bytes = 8192,
    localparam int num_lines   = cache_bytes / (cache_pkg::line_words * 4),
    localparam int index_bits  = $clog2(num_lines),
    localparam int tag_bits    = 32 - index_bits - cache_pkg::offset_bits - 2
) (
    input  logic                              upstream_intf,
    input  logic                              reset,
    input  cache_pkg::word_t                  up_haddr,
    input  cache_pkg::htrans_t                up_htrans,
    input  logic                              up_hwrite,
    input  logic                              up_hready,
    input  cache_pkg::word_t                  up_hwdata,
    input  logic                              req_done,
    output logic                              req_valid,
    output logic                              req_write,
    output logic [tag_bits-1:0]               req_tag,
    output logic [index_bits-1:0]             req_index,
    output logic [cache_pkg::offset_bits-1:0] req_offset,
    output cache_pkg::word_t                  req_addr,
    output cache_pkg::word_t                  req_wdata
);

    import cache_pkg::*;

    logic accept;

    assign accept = up_hready && (up_htrans == trans_nonseq || up_htrans == trans_seq);

    always_ff @(posedge upstream_intf) begin
        if (reset) begin
            req_valid <= 1'b0;
            req_write <= 1'b0;
        end else if (accept) begin
            req_valid <= 1'b1;  // back to back, a new request replaces the done one.
            req_write <= up_hwrite;
        end else if (req_done) begin
            req_valid <= 1'b0;
        end
    end

    always_ff @(posedge upstream_intf) begin
        if (accept) begin
            req_addr <= up_haddr;
        end
        // master keeps hwdata steady while the data phase is stretched.
        if (req_valid && req_write && !up_hready) begin
            req_wdata <= up_hwdata;
        end
    end

    // tag | index | word offset | byte offset.
    assign req_offset = req_addr[2 +: offset_bits];
    assign req_index  = req_addr[2 + offset_bits +: index_bits];
    assign req_tag    = req_addr[31 -: tag_bits];

    // master holds a stalled address phase.
    assert property (@(posedge upstream_intf) disable iff (reset)
        (up_htrans != trans_idle && !up_hready) |=> ($stable(up_haddr) && $stable(up_htrans)))
        else $error("upstream address phase changed while stalled.");

endmodule

// File: src/cache_pkg.sv
package cache_pkg;

    // ====================
    // ahb encodings
    // ====================

    typedef enum logic [1:0] {
        trans_idle   = 2'b00,
        trans_busy   = 2'b01,
        trans_nonseq = 2'b10,
        trans_seq    = 2'b11
    } htrans_t;

    // incr4 and the wider bursts are never issued.
    typedef enum logic [2:0] {
        burst_single = 3'b000,
        burst_incr   = 3'b001,
        burst_wrap4  = 3'b010
    } hburst_t;

    // ====================
    // line geometry
    // ====================

    typedef logic [31:0] word_t;

    localparam int line_words  = 4;
    localparam int offset_bits = $clog2(line_words);  // word offset in a line.

    typedef logic [line_words*32-1:0] line_t;

endpackage
